// File: common/spi_proto_pkg.sv
package spi_proto_pkg;

    // Bits moved in one transfer, also the data register width
    localparam int WORD_W = 16;

    // Bit counter wide enough to index every bit of a word
    localparam int CNT_W = 4;

    // Index of the final bit of a word
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(WORD_W - 1);

    // Shift engine states.
    // Every state other than IDLE lasts exactly one tick period,
    // so one transfer takes 2 + 2 * WORD_W ticks.
    typedef enum logic [2:0] {
        IDLE     = 3'd0,    // Waiting for start
        SELECT   = 3'd1,    // Chip select asserted, clock at idle
        DRIVE    = 3'd2,    // Clock at idle level, next bit on mosi
        SAMPLE   = 3'd3,    // Clock at active level, miso captured
        DESELECT = 3'd4     // Chip select released, done pulse
    } spi_state_t;

endpackage

// File: common/spi_reg_pkg.sv
package spi_reg_pkg;

    // Clock divisor width, bits 7:0 of the control word
    localparam int DIV_W = 8;

    // Divisor after reset
    localparam logic [DIV_W-1:0] DIV_RESET = 8'd3;

    // Host register map
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,  // Divisor and polarity bits
        REG_TXDATA = 2'd1,  // Write starts a transfer when idle
        REG_RXDATA = 2'd2,  // Last received word
        REG_STATUS = 2'd3   // Busy and sticky done
    } reg_addr_t;

    // Control word bit positions
    localparam int CTRL_CPOL_BIT  = 8;     // Idle level of sclk
    localparam int CTRL_CSPOL_BIT = 9;     // Active level of cs

    // Status word bit positions
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;      // Cleared by a STATUS read

endpackage

// File: common/spi_ctrl_if.sv
interface spi_ctrl_if import spi_proto_pkg::*, spi_reg_pkg::*; ();

    // Configuration and command, from the register block
    logic [DIV_W-1:0]  div;         // Tick every div+1 clocks
    logic              cpol;        // Idle level of sclk
    logic              cs_active;   // Asserted level of cs
    logic [WORD_W-1:0] tx_word;     // Word loaded on start
    logic              start;       // One-cycle request

    // Result and state, from the shift engine
    logic [WORD_W-1:0] rx_word;     // Valid from done onwards
    logic              done;        // One-cycle completion strobe
    logic              busy;        // High while a transfer runs

    modport regs (
        output div, cpol, cs_active, tx_word, start,
        input  rx_word, done, busy
    );

    modport engine (
        input  div, cpol, cs_active, tx_word, start,
        output rx_word, done, busy
    );

endinterface

// File: rtl/spi_regs.sv
module spi_regs import spi_proto_pkg::*, spi_reg_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  logic              rd_en,
    input  reg_addr_t         addr,
    input  logic [WORD_W-1:0] wdata,
    output logic [WORD_W-1:0] rdata,
    output logic              rdata_valid,
    spi_ctrl_if.regs          ctrl
);

    logic [WORD_W-1:0] tx_reg;      // Last accepted transmit word
    logic [WORD_W-1:0] ctrl_word;
    logic [WORD_W-1:0] stat_word;
    logic [WORD_W-1:0] read_word;
    logic              done_flag;   // Sticky until STATUS is read
    logic              tx_write;
    logic              ctrl_write;
    logic              stat_read;

    assign tx_write   = wr_en && (addr == REG_TXDATA);
    assign ctrl_write = wr_en && (addr == REG_CTRL);
    assign stat_read  = rd_en && (addr == REG_STATUS);

    // Writes during a transfer are dropped
    assign ctrl.start = tx_write && !ctrl.busy;

    // The engine loads on the strobe cycle itself, before tx_reg updates
    assign ctrl.tx_word = ctrl.start ? wdata : tx_reg;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrl.div       <= DIV_RESET;
            ctrl.cpol      <= 1'b0;
            ctrl.cs_active <= 1'b0;   // Active low chip select
            done_flag      <= 1'b0;
            rdata_valid    <= 1'b0;
        end
        else
        begin
            if (ctrl_write)
            begin
                ctrl.div       <= wdata[DIV_W-1:0];
                ctrl.cpol      <= wdata[CTRL_CPOL_BIT];
                ctrl.cs_active <= wdata[CTRL_CSPOL_BIT];
            end

            // A completion in the same cycle as the read wins
            if (ctrl.done)
                done_flag <= 1'b1;
            else if (stat_read)
                done_flag <= 1'b0;

            rdata_valid <= rd_en;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.start)
            tx_reg <= wdata;
        if (rd_en)
            rdata <= read_word;
    end

    always_comb
    begin
        ctrl_word                 = '0;
        ctrl_word[DIV_W-1:0]      = ctrl.div;
        ctrl_word[CTRL_CPOL_BIT]  = ctrl.cpol;
        ctrl_word[CTRL_CSPOL_BIT] = ctrl.cs_active;

        stat_word                = '0;
        stat_word[STAT_BUSY_BIT] = ctrl.busy;
        stat_word[STAT_DONE_BIT] = done_flag;   // Value before the clear
    end

    always_comb
    begin
        case (addr)
            REG_CTRL:   read_word = ctrl_word;
            REG_TXDATA: read_word = tx_reg;
            REG_RXDATA: read_word = ctrl.rx_word;
            REG_STATUS: read_word = stat_word;
            default:    read_word = '0;
        endcase
    end

endmodule

// File: spi_engine/spi_tick_gen.sv
module spi_tick_gen import spi_reg_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             run,
    input  logic [DIV_W-1:0] div,
    output logic             tick
);

    // Clock cycles already spent in the current tick period
    logic [DIV_W-1:0] count;

    // One enable every div+1 cycles, the first one div+1 cycles into run
    assign tick = run && (count == div);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (!run)
        begin
            // Held so every transfer begins on a full period
            count <= '0;
        end
        else if (tick)
        begin
            count <= '0;    // Start the next period
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

endmodule

// File: spi_engine/spi_shift_engine.sv
module spi_shift_engine import spi_proto_pkg::*, spi_reg_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    spi_ctrl_if.engine ctrl,
    output logic       sclk,
    output logic       mosi,
    input  logic       miso,
    output logic       cs
);

    spi_state_t        state;
    logic [WORD_W-1:0] tx_shift;    // Bit 0 is on mosi
    logic [WORD_W-1:0] rx_shift;    // Filled from the top
    logic [WORD_W-1:0] rx_hold;     // Completed word for the host
    logic [CNT_W-1:0]  bit_cnt;
    logic [DIV_W-1:0]  div_q;       // Divisor for this transfer
    logic              cpol_q;
    logic              cs_act_q;
    logic              run;
    logic              tick;
    logic              last_bit;

    assign run      = (state != IDLE);
    assign last_bit = (bit_cnt == LAST_BIT);

    assign ctrl.busy    = run;
    assign ctrl.done    = (state == DESELECT) && tick;
    assign ctrl.rx_word = rx_hold;

    assign mosi = tx_shift[0];     // Least significant bit first

    spi_tick_gen u_tick_gen (
        .clk   (clk),
        .reset (reset),
        .run   (run),
        .div   (div_q),
        .tick  (tick)
    );

    // State, pin levels and bit count
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= IDLE;
            bit_cnt  <= '0;
            cpol_q   <= 1'b0;
            cs_act_q <= 1'b0;
            sclk     <= 1'b0;
            cs       <= 1'b1;   // Inactive for the reset polarity
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (ctrl.start)
                    begin
                        cpol_q   <= ctrl.cpol;
                        cs_act_q <= ctrl.cs_active;
                        sclk     <= ctrl.cpol;
                        cs       <= ctrl.cs_active;   // Held through SELECT
                        bit_cnt  <= '0;
                        state    <= SELECT;
                    end
                end

                SELECT:
                begin
                    if (tick)
                        state <= DRIVE;
                end

                DRIVE:
                begin
                    if (tick)
                    begin
                        sclk  <= ~cpol_q;   // Leading edge
                        state <= SAMPLE;
                    end
                end

                SAMPLE:
                begin
                    if (tick)
                    begin
                        sclk <= cpol_q;     // Trailing edge
                        if (last_bit)
                        begin
                            state <= DESELECT;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state   <= DRIVE;
                        end
                    end
                end

                DESELECT:
                begin
                    if (tick)
                    begin
                        cs    <= ~cs_act_q;
                        state <= IDLE;
                    end
                end

                default:
                    state <= IDLE;
            endcase
        end
    end

    // Data path
    always_ff @(posedge clk)
    begin
        if ((state == IDLE) && ctrl.start)
        begin
            tx_shift <= ctrl.tx_word;   // First bit appears right away
            div_q    <= ctrl.div;
        end

        // Next bit goes out together with the trailing edge
        if ((state == SAMPLE) && tick && !last_bit)
            tx_shift <= {1'b0, tx_shift[WORD_W-1:1]};

        // Capture on the leading edge
        if ((state == DRIVE) && tick)
            rx_shift <= {miso, rx_shift[WORD_W-1:1]};

        if ((state == SAMPLE) && tick && last_bit)
            rx_hold <= rx_shift;
    end

endmodule

// File: rtl/spi_master_top.sv
module spi_master_top import spi_proto_pkg::*, spi_reg_pkg::*; (
    input  logic              clk,
    input  logic              reset,

    // Host side
    input  logic              wr_en,
    input  logic              rd_en,
    input  reg_addr_t         addr,
    input  logic [WORD_W-1:0] wdata,
    output logic [WORD_W-1:0] rdata,
    output logic              rdata_valid,
    output logic              transfer_done,

    // Serial side
    output logic              sclk,
    output logic              mosi,
    input  logic              miso,
    output logic              cs
);

    spi_ctrl_if ctrl_bus ();

    spi_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .rd_en       (rd_en),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .ctrl        (ctrl_bus.regs)
    );

    spi_shift_engine u_engine (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl_bus.engine),
        .sclk  (sclk),
        .mosi  (mosi),
        .miso  (miso),
        .cs    (cs)
    );

    // Same strobe that sets the sticky done bit
    assign transfer_done = ctrl_bus.done;

endmodule

// File: tb/spi_slave_model.sv
module spi_slave_model import spi_proto_pkg::*; (
    input  logic              sclk,
    input  logic              mosi,
    output logic              miso,
    input  logic              cpol,       // Idle level of sclk for this transfer
    input  logic              load,       // Rising edge arms the next transfer
    input  logic [WORD_W-1:0] preset,     // Word returned on miso
    output logic [WORD_W-1:0] captured,   // Word seen on mosi
    output int                edges       // Leading edges since the last load
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [WORD_W-1:0] miso_word = '0;  // Copy of the preset word
    logic [WORD_W-1:0] cap_word  = '0;
    logic              miso_bit  = 1'b0;
    int                lead_cnt  = 0;

    assign miso     = miso_bit;
    assign captured = cap_word;
    assign edges    = lead_cnt;

    // Reacts to the serial clock itself, like a real slave device
    always @(posedge load or posedge sclk or negedge sclk)
    begin
        if (load)
        begin
            miso_word = preset;
            cap_word  = '0;
            lead_cnt  = 0;
            miso_bit  = preset[0];      // Ready before the first leading edge
        end
        else if (sclk === ~cpol)
        begin
            // Leading edge, LSB arrives first and ends up at bit 0
            cap_word = {mosi, cap_word[WORD_W-1:1]};
            lead_cnt = lead_cnt + 1;
        end
        else if (lead_cnt < WORD_W)
        begin
            // Trailing edge
            // Also hit when the master moves sclk to a new idle level at start
            miso_bit = miso_word[lead_cnt[CNT_W-1:0]];
        end
    end

endmodule

// File: tb/tb_spi_master.sv
module tb_spi_master import spi_proto_pkg::*, spi_reg_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD  = 4;
    localparam int          RESET_CYC   = 10;
    localparam int          N_RAND      = 40;
    localparam int          N_XFER      = N_RAND + 1;
    localparam int          XFER_TICKS  = 2 + 2 * WORD_W;     // SELECT, bits, DESELECT
    localparam int          DONE_LIMIT  = XFER_TICKS * 9;
    localparam int          WATCHDOG_NS = N_XFER * XFER_TICKS * 9 * CLK_PERIOD + 2000;
    localparam logic [31:0] SEED        = 32'hfca1_fd34;

    logic              clk = 1'b0;
    logic              reset;
    logic              wr_en;
    logic              rd_en;
    reg_addr_t         addr;
    logic [WORD_W-1:0] wdata;
    logic [WORD_W-1:0] rdata;
    logic              rdata_valid;
    logic              transfer_done;
    logic              sclk;
    logic              mosi;
    logic              miso;
    logic              cs;

    logic              s_load;
    logic              s_cpol;
    logic [WORD_W-1:0] s_preset;
    logic [WORD_W-1:0] s_captured;
    int                s_edges;

    // Reference model of the configuration
    int                m_div;
    logic              m_cpol;
    logic              m_csact;

    int                errs = 0;
    int                mon_errs = 0;
    int                err_snap = 0;
    int                pass_cnt = 0;
    int                fail_cnt = 0;
    logic              mon_active = 1'b0;  // Set while a transfer is expected

    // Pin monitor state
    int                cyc_now = 0;
    int                last_lead = 0;
    logic              sclk_q = 1'b0;
    logic              act_q = 1'b0;
    logic              seen_lead = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    spi_master_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .addr          (addr),
        .wdata         (wdata),
        .rdata         (rdata),
        .rdata_valid   (rdata_valid),
        .transfer_done (transfer_done),
        .sclk          (sclk),
        .mosi          (mosi),
        .miso          (miso),
        .cs            (cs)
    );

    spi_slave_model slave0 (
        .sclk     (sclk),
        .mosi     (mosi),
        .miso     (miso),
        .cpol     (s_cpol),
        .load     (s_load),
        .preset   (s_preset),
        .captured (s_captured),
        .edges    (s_edges)
    );

    task automatic check(input string name, input logic [WORD_W-1:0] exp,
                         input logic [WORD_W-1:0] act);
        if (act !== exp)
        begin
            $display("ERR %0d ns %s expected %h got %h", $time, name, exp, act);
            errs++;
        end
    endtask

    function automatic logic [WORD_W-1:0] pack_ctrl(input logic [DIV_W-1:0] div,
                                                    input logic cpol, input logic cspol);
        logic [WORD_W-1:0] w;
        w                 = '0;
        w[DIV_W-1:0]      = div;
        w[CTRL_CPOL_BIT]  = cpol;
        w[CTRL_CSPOL_BIT] = cspol;
        return w;
    endfunction

    task automatic reg_write(input reg_addr_t a, input logic [WORD_W-1:0] d);
        @(negedge clk);
        wr_en = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t a, output logic [WORD_W-1:0] d);
        @(negedge clk);
        rd_en = 1'b1;
        addr  = a;
        @(negedge clk);
        rd_en = 1'b0;
        check("rdata_valid", 16'h0001, WORD_W'(rdata_valid));   // One cycle after rd_en
        d = rdata;
    endtask

    task automatic slave_load(input logic [WORD_W-1:0] word);
        @(negedge clk);
        s_preset = word;
        s_cpol   = m_cpol;
        s_load   = 1'b1;
        @(negedge clk);
        s_load = 1'b0;
    endtask

    // Cycles counted from the negedge that raised wr_en
    task automatic wait_done(output int cyc);
        cyc = 1;
        while (!transfer_done && cyc < DONE_LIMIT)
        begin
            @(negedge clk);
            cyc++;
        end
        if (!transfer_done)
        begin
            $display("Transfer never signalled done within %0d cycles", cyc);
            errs++;
        end
    endtask

    task automatic start_test();
        err_snap = errs + mon_errs;
    endtask

    task automatic end_test(input string name);
        if (errs + mon_errs == err_snap)
        begin
            pass_cnt++;
            $display("PASS %s", name);
        end
        else
        begin
            fail_cnt++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic run_random(input int idx);
        logic [WORD_W-1:0] tx;
        logic [WORD_W-1:0] rx;
        logic [WORD_W-1:0] rd;
        int                lat;

        start_test();
        m_div   = int'($urandom % 8);
        m_cpol  = 1'($urandom);
        m_csact = 1'($urandom);
        tx      = WORD_W'($urandom);
        rx      = WORD_W'($urandom);
        reg_write(REG_CTRL, pack_ctrl(DIV_W'(m_div), m_cpol, m_csact));
        slave_load(rx);
        mon_active = 1'b1;
        reg_write(REG_TXDATA, tx);
        wait_done(lat);
        mon_active = 1'b0;
        check("latency", WORD_W'(XFER_TICKS * (m_div + 1)), WORD_W'(lat));
        @(negedge clk);
        check("slave_captured", tx, s_captured);
        check("leading_edges", WORD_W'(WORD_W), WORD_W'(s_edges));
        check("sclk", WORD_W'(m_cpol), WORD_W'(sclk));     // Back at rest
        check("cs", WORD_W'(!m_csact), WORD_W'(cs));
        reg_read(REG_RXDATA, rd);
        check("rxdata", rx, rd);
        end_test($sformatf("transfer %0d div %0d cpol %0d cspol %0d",
                           idx, m_div, m_cpol, m_csact));
    endtask

    // Serial pin monitor, sampled where all DUT outputs are settled
    always @(negedge clk)
    begin
        cyc_now++;
        if (mon_active && !act_q)
            seen_lead = 1'b0;
        act_q = mon_active;
        if (mon_active && sclk !== sclk_q && sclk === ~m_cpol)
        begin
            if (seen_lead && (cyc_now - last_lead) != 2 * (m_div + 1))
            begin
                $display("ERR %0d ns sclk_period expected %0d got %0d",
                         $time, 2 * (m_div + 1), cyc_now - last_lead);
                mon_errs++;
            end
            seen_lead = 1'b1;
            last_lead = cyc_now;
        end
        if (mon_active && seen_lead && cs !== m_csact)
        begin
            $display("ERR %0d ns cs expected %b got %b", $time, m_csact, cs);
            mon_errs++;
        end
        sclk_q = sclk;
    end

    initial
    begin
        logic [WORD_W-1:0] rd;
        logic [WORD_W-1:0] tx;
        logic [WORD_W-1:0] rx;
        int                lat;

        void'($urandom(SEED));
        reset    = 1'b1;
        wr_en    = 1'b0;
        rd_en    = 1'b0;
        addr     = REG_CTRL;
        wdata    = '0;
        s_load   = 1'b1;    // Slave held cleared during reset
        s_cpol   = 1'b0;
        s_preset = '0;
        m_div    = 3;
        m_cpol   = 1'b0;
        m_csact  = 1'b0;
        repeat (RESET_CYC) @(negedge clk);
        reset  = 1'b0;
        s_load = 1'b0;

        start_test();
        check("cs", 16'h0001, WORD_W'(cs));
        check("sclk", 16'h0000, WORD_W'(sclk));
        check("transfer_done", 16'h0000, WORD_W'(transfer_done));
        reg_read(REG_STATUS, rd);
        check("status", 16'h0000, rd);
        reg_read(REG_CTRL, rd);
        check("ctrl", 16'h0003, rd);    // Divisor 3, both polarities low
        end_test("reset state");

        for (int i = 0; i < N_RAND; i++)
            run_random(i);

        start_test();
        m_div   = 7;
        m_cpol  = 1'b0;
        m_csact = 1'b0;
        tx      = WORD_W'($urandom);
        rx      = WORD_W'($urandom);
        reg_write(REG_CTRL, pack_ctrl(DIV_W'(m_div), m_cpol, m_csact));
        reg_read(REG_STATUS, rd);       // Clears done left from earlier transfers
        slave_load(rx);
        mon_active = 1'b1;
        reg_write(REG_TXDATA, tx);
        reg_write(REG_TXDATA, ~tx);     // Must be ignored while busy
        reg_read(REG_STATUS, rd);
        check("status_busy", 16'h0001, rd);
        wait_done(lat);
        mon_active = 1'b0;
        @(negedge clk);
        check("slave_captured", tx, s_captured);
        reg_read(REG_TXDATA, rd);
        check("txdata", tx, rd);
        reg_read(REG_STATUS, rd);
        check("status_done", 16'h0002, rd);
        reg_read(REG_STATUS, rd);
        check("status_cleared", 16'h0000, rd);
        end_test("dropped write and sticky done");

        $display("Summary: %0d pass, %0d fail", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Watchdog sized for the slowest divisor plus some margin
    initial
    begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: src.f
common/spi_proto_pkg.sv
common/spi_reg_pkg.sv
common/spi_ctrl_if.sv
rtl/spi_regs.sv
spi_engine/spi_tick_gen.sv
spi_engine/spi_shift_engine.sv
rtl/spi_master_top.sv
tb/spi_slave_model.sv
tb/tb_spi_master.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary -f src.f --top-module tb_spi_master -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -x "All tests passed" > /dev/null \
    && echo "Simulation: PASS" \
    || { echo "Simulation: FAIL"; exit 1; }
